/* hdl/pin_macros.svh */
`ifndef PIN_MACROS_SVH
`define PIN_MACROS_SVH

// number of pin channels in the array.
`define PIN_COUNT 4

// host data and register width.
`define DATA_W 16
`define ADDR_W 19

// address field that selects a channel.
`define POS_HI 15
`define POS_LO 8
`define POS_W (`POS_HI - `POS_LO + 1)

`endif

/* hdl/pin_pkg.sv */
`default_nettype none

`include "pin_macros.svh"

package pin_pkg;

  // one-hot channel states.
  typedef enum logic [4:0] {
    st_idle         = 5'b00001,
    st_high         = 5'b00010,
    st_low          = 5'b00100,
    st_input_stream = 5'b01000,
    st_const_level  = 5'b10000
  } pin_state_e;

  // command codes written to the local command register.
  // write_pin and local_start are reserved and ignored.
  typedef enum logic [`DATA_W-1:0] {
    cmd_none         = 16'd0,
    cmd_start_output = 16'd1,
    cmd_write_pin    = 16'd2,
    cmd_input_stream = 16'd3,
    cmd_local_start  = 16'd4,
    cmd_reset        = 16'd5,
    cmd_const_level  = 16'd6
  } pin_cmd_e;

  // byte offsets inside a channel window.
  typedef enum logic [`POS_LO-1:0] {
    reg_duty        = 8'd1,
    reg_anti_duty   = 8'd2,
    reg_cycles      = 8'd3,
    reg_run_inf     = 8'd4,
    reg_local_cmd   = 8'd5,
    reg_sample_rate = 8'd6,
    reg_sample_reg  = 8'd7,
    reg_sample_cnt  = 8'd8,
    reg_status      = 8'd9
  } reg_offset_e;

endpackage

`default_nettype wire

/* hdl/pin_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pin_macros.svh"

// one host access as seen by a single channel.
interface pin_bus_if;

  logic                enable;
  logic [`ADDR_W-1:0]  addr;
  logic [`DATA_W-1:0]  data_in;
  logic                data_wr;
  logic                data_rd;
  // address hit for this channel, or a global write.
  logic                sel;

  modport source (
    output enable, addr, data_in, data_wr, data_rd, sel
  );

  modport sink (
    input enable, addr, data_in, data_wr, data_rd, sel
  );

endinterface

`default_nettype wire

/* hdl/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pin_macros.svh"

module bus_decoder
  import pin_pkg::*;
(
  input  wire logic                clk,
  input  wire logic                reset,
  input  wire logic                enable,
  input  wire logic [`ADDR_W-1:0]  addr,
  input  wire logic [`DATA_W-1:0]  data_in,
  input  wire logic                data_wr,
  input  wire logic                data_rd,
  pin_bus_if.source                chan_bus [`PIN_COUNT],
  output logic      [`POS_W-1:0]   read_pos
);

  logic [`POS_W-1:0]  pos;
  logic               global_wr;
  logic [`ADDR_W-1:0] chan_addr;

  assign pos       = addr[`POS_HI:`POS_LO];
  assign global_wr = data_wr && (addr == '0);

  // a global write lands on every channel as a local command write.
  assign chan_addr = global_wr ? `ADDR_W'(reg_local_cmd) : addr;

  for (genvar i = 0; i < `PIN_COUNT; i++) begin : g_chan
    assign chan_bus[i].enable  = enable;
    assign chan_bus[i].addr    = chan_addr;
    assign chan_bus[i].data_in = data_in;
    assign chan_bus[i].data_wr = data_wr;
    assign chan_bus[i].data_rd = data_rd;
    // channel i sits at position i+1.
    assign chan_bus[i].sel     = global_wr || (pos == `POS_W'(i + 1));
  end

  // remember which position was read so the return mux can pick it.
  always_ff @(posedge clk) begin
    if (reset) begin
      read_pos <= '0;
    end else if (enable && data_rd) begin
      read_pos <= pos;
    end else begin
      read_pos <= '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/pin_channel.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pin_macros.svh"

module pin_channel
  import pin_pkg::*;
(
  input  wire logic               clk,
  input  wire logic               reset,
  pin_bus_if.sink                 bus,
  input  wire logic [`POS_W-1:0]  position,
  input  wire logic               pin_in,
  output logic      [`DATA_W-1:0] rd_data,
  output logic                    pin_out,
  output logic                    pin_oe
);

  // configuration registers.
  pin_cmd_e           command;
  logic [`DATA_W-1:0] duty_cycle;
  logic [`DATA_W-1:0] anti_duty_cycle;
  logic [`DATA_W-1:0] cycles;
  logic [`DATA_W-1:0] run_inf;
  logic [`DATA_W-1:0] sample_rate;

  // down-counters.
  logic [`DATA_W-1:0] cnt_duty;
  logic [`DATA_W-1:0] cnt_anti_duty;
  logic [`DATA_W-1:0] cnt_cycles;
  logic [`DATA_W-1:0] cnt_sample;

  logic               sample_reg;
  logic [`DATA_W-1:0] sample_cnt;

  pin_state_e         state;
  pin_state_e         next_state;

  // fsm controls.
  logic load_duty;
  logic dec_duty;
  logic load_anti;
  logic dec_anti;
  logic load_cycles;
  logic dec_cycles;
  logic load_sample;
  logic dec_sample;
  logic take_sample;
  logic clear_cmd;

  reg_offset_e offset;
  logic        wr_hit;
  logic        rd_hit;

  assign offset = reg_offset_e'(bus.addr[`POS_LO-1:0]);
  assign wr_hit = bus.enable && bus.sel && bus.data_wr;
  assign rd_hit = bus.enable && bus.sel && bus.data_rd;

  // register file; a host write wins over the fsm clearing the command.
  always_ff @(posedge clk) begin
    if (reset) begin
      command         <= cmd_none;
      duty_cycle      <= '0;
      anti_duty_cycle <= '0;
      cycles          <= '0;
      run_inf         <= '0;
      sample_rate     <= '0;
    end else begin
      if (clear_cmd) begin
        command <= cmd_none;
      end
      if (wr_hit) begin
        case (offset)
          reg_local_cmd:   command         <= pin_cmd_e'(bus.data_in);
          reg_duty:        duty_cycle      <= bus.data_in;
          reg_anti_duty:   anti_duty_cycle <= bus.data_in;
          reg_cycles:      cycles          <= bus.data_in;
          reg_run_inf:     run_inf         <= bus.data_in;
          reg_sample_rate: sample_rate     <= bus.data_in;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load_duty) begin
      cnt_duty <= duty_cycle;
    end else if (dec_duty) begin
      cnt_duty <= cnt_duty - 1'b1;
    end

    if (load_anti) begin
      cnt_anti_duty <= anti_duty_cycle;
    end else if (dec_anti) begin
      cnt_anti_duty <= cnt_anti_duty - 1'b1;
    end

    // the period count is frozen while running forever.
    if (load_cycles) begin
      cnt_cycles <= cycles;
    end else if (dec_cycles && (run_inf == '0)) begin
      cnt_cycles <= cnt_cycles - 1'b1;
    end

    if (load_sample) begin
      cnt_sample <= sample_rate;
    end else if (dec_sample) begin
      cnt_sample <= cnt_sample - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      sample_reg <= 1'b0;
      sample_cnt <= '0;
    end else if (take_sample) begin
      sample_reg <= pin_in;
      sample_cnt <= sample_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state  = state;
    load_duty   = 1'b0;
    dec_duty    = 1'b0;
    load_anti   = 1'b0;
    dec_anti    = 1'b0;
    load_cycles = 1'b0;
    dec_cycles  = 1'b0;
    load_sample = 1'b0;
    dec_sample  = 1'b0;
    take_sample = 1'b0;
    clear_cmd   = 1'b0;
    case (state)
      st_idle: begin
        // keep all counters armed while waiting.
        load_duty   = 1'b1;
        load_anti   = 1'b1;
        load_cycles = 1'b1;
        load_sample = 1'b1;
        case (command)
          cmd_start_output: begin
            next_state = st_high;
            clear_cmd  = 1'b1;
          end
          cmd_input_stream: begin
            next_state = st_input_stream;
            clear_cmd  = 1'b1;
          end
          cmd_const_level: begin
            next_state = st_const_level;
            clear_cmd  = 1'b1;
          end
          default: ;
        endcase
      end
      st_high: begin
        if (command == cmd_reset) begin
          next_state = st_idle;
          clear_cmd  = 1'b1;
        end else if (cnt_duty <= `DATA_W'(1)) begin
          next_state = st_low;
          load_duty  = 1'b1;
        end else begin
          dec_duty = 1'b1;
        end
      end
      st_low: begin
        if (command == cmd_reset) begin
          next_state = st_idle;
          clear_cmd  = 1'b1;
        end else if (cnt_anti_duty <= `DATA_W'(1)) begin
          // end of one period.
          load_anti  = 1'b1;
          dec_cycles = 1'b1;
          if ((run_inf == '0) && (cnt_cycles <= `DATA_W'(1))) begin
            next_state = st_idle;
          end else begin
            next_state = st_high;
          end
        end else begin
          dec_anti = 1'b1;
        end
      end
      st_input_stream: begin
        if (cnt_sample <= `DATA_W'(1)) begin
          take_sample = 1'b1;
          load_sample = 1'b1;
        end else begin
          dec_sample = 1'b1;
        end
        if (command == cmd_reset) begin
          next_state = st_idle;
          clear_cmd  = 1'b1;
        end
      end
      st_const_level: begin
        if (command == cmd_reset) begin
          next_state = st_idle;
          clear_cmd  = 1'b1;
        end
      end
      default: begin
        next_state = st_idle;
      end
    endcase
  end

  // pin drive follows the state one clock later.
  always_ff @(posedge clk) begin
    if (reset) begin
      pin_out <= 1'b0;
      pin_oe  <= 1'b0;
    end else begin
      pin_oe  <= (state == st_high) || (state == st_low) || (state == st_const_level);
      pin_out <= (state == st_high) ||
                 ((state == st_const_level) && (duty_cycle != '0));
    end
  end

  // read word; unselected channels return zero.
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_data <= '0;
    end else if (rd_hit) begin
      case (offset)
        reg_sample_reg: rd_data <= `DATA_W'(sample_reg);
        reg_sample_cnt: rd_data <= sample_cnt;
        reg_status:     rd_data <= `DATA_W'(position);
        default:        rd_data <= '0;
      endcase
    end else begin
      rd_data <= '0;
    end
  end

endmodule

`default_nettype wire

/* hdl/read_return_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pin_macros.svh"

module read_return_mux (
  input  wire logic [`POS_W-1:0]  read_pos,
  input  wire logic [`DATA_W-1:0] chan_rd_data [`PIN_COUNT],
  output logic      [`DATA_W-1:0] data_out
);

  // channel i answers at position i+1.
  // position 0 and anything past the last channel read as zero.
  always_comb begin
    data_out = '0;
    for (int i = 0; i < `PIN_COUNT; i++) begin
      if (read_pos == `POS_W'(i + 1)) begin
        data_out = chan_rd_data[i];
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/pin_array_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pin_macros.svh"

module pin_array_top (
  input  wire logic                  clk,
  input  wire logic                  reset,
  input  wire logic                  enable,
  input  wire logic [`ADDR_W-1:0]    addr,
  input  wire logic [`DATA_W-1:0]    data_in,
  input  wire logic                  data_wr,
  input  wire logic                  data_rd,
  output logic      [`DATA_W-1:0]    data_out,
  input  wire logic [`PIN_COUNT-1:0] pin_in,
  output logic      [`PIN_COUNT-1:0] pin_out,
  output logic      [`PIN_COUNT-1:0] pin_oe
);

  pin_bus_if chan_bus [`PIN_COUNT] ();

  logic [`POS_W-1:0]  read_pos;
  logic [`DATA_W-1:0] chan_rd_data [`PIN_COUNT];

  bus_decoder decoder_i (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .addr     (addr),
    .data_in  (data_in),
    .data_wr  (data_wr),
    .data_rd  (data_rd),
    .chan_bus (chan_bus),
    .read_pos (read_pos)
  );

  for (genvar i = 0; i < `PIN_COUNT; i++) begin : g_pin
    pin_channel channel_i (
      .clk      (clk),
      .reset    (reset),
      .bus      (chan_bus[i]),
      .position (`POS_W'(i + 1)),
      .pin_in   (pin_in[i]),
      .rd_data  (chan_rd_data[i]),
      .pin_out  (pin_out[i]),
      .pin_oe   (pin_oe[i])
    );
  end

  read_return_mux return_mux_i (
    .read_pos     (read_pos),
    .chan_rd_data (chan_rd_data),
    .data_out     (data_out)
  );

endmodule

`default_nettype wire

/* verification/pin_array_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pin_macros.svh"

module pin_array_tb
  import pin_pkg::*;
();

  // cycle budget of each test; the timeout allows twice the sum.
  localparam int reset_len   = 4;
  localparam int status_len  = 30;
  localparam int pulse_len   = 110;
  localparam int const_len   = 25;
  localparam int stream_len  = 90;
  localparam int global_len  = 15;
  localparam int cycle_limit = 2 * (reset_len + status_len + pulse_len + const_len +
                                    stream_len + global_len);
  localparam int stream_wait = 64;

  logic                  clk;
  logic                  reset;
  logic                  enable;
  logic [`ADDR_W-1:0]    addr;
  logic [`DATA_W-1:0]    data_in;
  logic                  data_wr;
  logic                  data_rd;
  logic [`DATA_W-1:0]    data_out;
  logic [`PIN_COUNT-1:0] pin_in;
  logic [`PIN_COUNT-1:0] pin_out;
  logic [`PIN_COUNT-1:0] pin_oe;

  logic [15:0] lfsr;
  int cycle_cnt = 0;
  int error_cnt = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int errors_before = 0;

  // model of each channel's configuration registers.
  int model_duty [`PIN_COUNT] = '{default: 0};
  int model_anti [`PIN_COUNT] = '{default: 0};
  int model_cycles [`PIN_COUNT] = '{default: 0};
  int model_rate [`PIN_COUNT] = '{default: 0};

  pin_array_top dut_i (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .addr     (addr),
    .data_in  (data_in),
    .data_wr  (data_wr),
    .data_rd  (data_rd),
    .data_out (data_out),
    .pin_in   (pin_in),
    .pin_out  (pin_out),
    .pin_oe   (pin_oe)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
      $display("sim failed");
      $finish;
    end
  end

  // galois lfsr with taps for x^16 + x^14 + x^13 + x^11 + 1.
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = s >> 1;
    if (s[0]) begin
      lfsr_next = lfsr_next ^ 16'hB400;
    end
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic int at_least_one(input int v);
    return (v < 1) ? 1 : v;
  endfunction

  function automatic logic [`ADDR_W-1:0] chan_addr(input int pos, input int off);
    return `ADDR_W'({`POS_W'(pos), 8'(off)});
  endfunction

  task automatic mismatch(input string name, input logic [`DATA_W-1:0] exp,
                          input logic [`DATA_W-1:0] got);
    $display("ERROR %0t %s expected %h got %h", $time, name, exp, got);
    error_cnt++;
  endtask

  task automatic fault(input string what);
    $display("FAULT %0t %s", $time, what);
    error_cnt++;
  endtask

  task automatic end_test(input string name);
    int errs;
    errs = error_cnt - errors_before;
    tests_run++;
    if (errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errs);
    end
    errors_before = error_cnt;
  endtask

  task automatic bus_write(input logic [`ADDR_W-1:0] a, input logic [`DATA_W-1:0] d);
    enable  = 1'b1;
    data_wr = 1'b1;
    addr    = a;
    data_in = d;
    @(negedge clk);
    enable  = 1'b0;
    data_wr = 1'b0;
  endtask

  task automatic chan_write(input int ch, input reg_offset_e off, input int val);
    case (off)
      reg_duty:        model_duty[ch] = val;
      reg_anti_duty:   model_anti[ch] = val;
      reg_cycles:      model_cycles[ch] = val;
      reg_sample_rate: model_rate[ch] = val;
      default: ;
    endcase
    bus_write(chan_addr(ch + 1, off), `DATA_W'(val));
  endtask

  // the read word is valid in the cycle after the sampling edge.
  task automatic bus_read(input int pos, input int off, output logic [`DATA_W-1:0] val);
    enable  = 1'b1;
    data_rd = 1'b1;
    addr    = chan_addr(pos, off);
    @(negedge clk);
    enable  = 1'b0;
    data_rd = 1'b0;
    val     = data_out;
  endtask

  task automatic wait_oe(input logic [`PIN_COUNT-1:0] mask, input logic [`PIN_COUNT-1:0] want,
                         input int limit, input string what);
    int n;
    n = 0;
    while (((pin_oe & mask) != want) && (n < limit)) begin
      @(negedge clk);
      n++;
    end
    if ((pin_oe & mask) != want) fault(what);
  endtask

  initial begin
    logic [`DATA_W-1:0]    rd;
    logic [`PIN_COUNT-1:0] bit_mask;
    logic                  run_level;
    int ch, d, a, cyc, rate, pins, level, exp_len, cnt0, cnt1, run_len, high_total;

    clk     = 1'b0;
    reset   = 1'b1;
    enable  = 1'b0;
    addr    = '0;
    data_in = '0;
    data_wr = 1'b0;
    data_rd = 1'b0;
    pin_in  = '0;
    lfsr    = 16'd41;
    repeat (4) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    if (pin_oe !== '0) mismatch("pin_oe", '0, `DATA_W'(pin_oe));
    if (data_out !== '0) mismatch("data_out", '0, data_out);
    for (int p = 1; p <= `PIN_COUNT; p++) begin
      bus_read(p, reg_status, rd);
      if (rd !== `DATA_W'(p)) mismatch("data_out", `DATA_W'(p), rd);
    end
    for (int off = 1; off <= 9; off++) begin
      bus_read(0, off, rd);
      if (rd !== '0) mismatch("data_out", '0, rd);
      bus_read(`PIN_COUNT + 1, off, rd);
      if (rd !== '0) mismatch("data_out", '0, rd);
    end
    end_test("status_reads");

    take_bits(2, ch);
    ch = ch % `PIN_COUNT;
    bit_mask = '0;
    bit_mask[ch] = 1'b1;
    take_bits(3, d);
    take_bits(3, a);
    take_bits(3, cyc);
    chan_write(ch, reg_duty, at_least_one(d));
    chan_write(ch, reg_anti_duty, at_least_one(a));
    chan_write(ch, reg_cycles, at_least_one(cyc));
    chan_write(ch, reg_run_inf, 0);
    chan_write(ch, reg_local_cmd, cmd_start_output);
    wait_oe(bit_mask, bit_mask, 4, "pulse train never enabled its pin");
    run_len = 0;
    run_level = 1'b1;
    high_total = 0;
    // measure each high and low run while the pin is driven.
    while (pin_oe[ch]) begin
      if ((pin_oe & ~bit_mask) !== '0) mismatch("pin_oe", '0, `DATA_W'(pin_oe));
      if (pin_out[ch] == run_level) begin
        run_len++;
      end else begin
        exp_len = run_level ? at_least_one(model_duty[ch]) : at_least_one(model_anti[ch]);
        if (run_len != exp_len) mismatch("pin_out run", `DATA_W'(exp_len), `DATA_W'(run_len));
        run_level = pin_out[ch];
        run_len = 1;
      end
      if (pin_out[ch]) high_total++;
      @(negedge clk);
    end
    if (run_level) begin
      fault("pulse train ended on a high level");
    end else if (run_len != at_least_one(model_anti[ch])) begin
      mismatch("pin_out run", `DATA_W'(at_least_one(model_anti[ch])), `DATA_W'(run_len));
    end
    exp_len = at_least_one(model_duty[ch]) * at_least_one(model_cycles[ch]);
    if (high_total != exp_len) mismatch("pin_out", `DATA_W'(exp_len), `DATA_W'(high_total));
    if (pin_oe !== '0) mismatch("pin_oe", '0, `DATA_W'(pin_oe));
    end_test("pulse_train");

    take_bits(2, ch);
    ch = ch % `PIN_COUNT;
    bit_mask = '0;
    bit_mask[ch] = 1'b1;
    take_bits(4, d);
    // first a nonzero duty, then zero.
    for (int k = 0; k < 2; k++) begin
      chan_write(ch, reg_duty, (k == 0) ? at_least_one(d) : 0);
      chan_write(ch, reg_local_cmd, cmd_const_level);
      wait_oe(bit_mask, bit_mask, 4, "constant level never enabled its pin");
      if (pin_out[ch] !== (model_duty[ch] != 0)) begin
        mismatch("pin_out", `DATA_W'(model_duty[ch] != 0), `DATA_W'(pin_out[ch]));
      end
      chan_write(ch, reg_local_cmd, cmd_reset);
      wait_oe(bit_mask, '0, 3, "reset command did not release the pin");
    end
    end_test("const_level");

    take_bits(2, ch);
    ch = ch % `PIN_COUNT;
    take_bits(3, rate);
    take_bits(`PIN_COUNT, pins);
    pin_in = `PIN_COUNT'(pins);
    level = int'(pin_in[ch]);
    chan_write(ch, reg_sample_rate, at_least_one(rate));
    chan_write(ch, reg_local_cmd, cmd_input_stream);
    repeat (16) @(negedge clk);
    bus_read(ch + 1, reg_sample_reg, rd);
    if (rd !== `DATA_W'(level)) mismatch("sample_reg", `DATA_W'(level), rd);
    bus_read(ch + 1, reg_sample_cnt, rd);
    cnt0 = int'(rd);
    repeat (stream_wait) @(negedge clk);
    bus_read(ch + 1, reg_sample_cnt, rd);
    cnt1 = int'(rd);
    // the two count reads are sampled stream_wait + 1 clocks apart.
    exp_len = (stream_wait + 1) / at_least_one(model_rate[ch]);
    if ((cnt1 - cnt0 < exp_len - 1) || (cnt1 - cnt0 > exp_len + 1)) begin
      mismatch("sample_cnt", `DATA_W'(exp_len), `DATA_W'(cnt1 - cnt0));
    end
    if (pin_oe !== '0) mismatch("pin_oe", '0, `DATA_W'(pin_oe));
    chan_write(ch, reg_local_cmd, cmd_reset);
    end_test("input_stream");

    bus_write('0, cmd_const_level);
    wait_oe('1, '1, 4, "global constant level did not enable every pin");
    for (int i = 0; i < `PIN_COUNT; i++) begin
      if (pin_out[i] !== (model_duty[i] != 0)) begin
        mismatch("pin_out", `DATA_W'(model_duty[i] != 0), `DATA_W'(pin_out[i]));
      end
    end
    bus_write('0, cmd_reset);
    wait_oe('1, '0, 3, "global reset command did not release every pin");
    end_test("global_command");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, error_cnt);
    if (error_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/pin_pkg.sv
hdl/pin_bus_if.sv
hdl/bus_decoder.sv
hdl/pin_channel.sv
hdl/read_return_mux.sv
hdl/pin_array_top.sv
verification/pin_array_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pin array testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f list.f --top-module pin_array_tb \
  -o pin_array_sim || { echo "build failed"; exit 1; }

sim_out=$(./obj_dir/pin_array_sim)
echo "$sim_out"
echo "$sim_out" | grep -qx "sim passed" && exit 0 || exit 1
